/* compile.f */
+incdir+include
source/pctrl_pkg.sv
source/pctrl_apb_bus.sv
source/pctrl_reset_seq.sv
source/pctrl_platform_regs.sv
source/pctrl_design_info.sv
source/pctrl_top.sv
test/tb_pctrl.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_pctrl -f compile.f
./obj_dir/Vtb_pctrl | tee sim.log

if grep -qF '*** FAILED ***' sim.log
then
	echo "Simulation failed"
	exit 1
fi
if ! grep -qF '*** PASSED ***' sim.log
then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

/* include/tb_pctrl_tasks.svh */
`ifndef TB_PCTRL_TASKS_SVH
`define TB_PCTRL_TASKS_SVH

// **************************************************
// Error reporting
// **************************************************
task automatic stop_on_failure();
	error_count++;
	$display("*** FAILED ***");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic report_failure(input string what);
	$display("%s", what);
	stop_on_failure();
endtask

task automatic expect_equal(input string name, input logic [BW_DATA-1:0] got,
	input logic [BW_DATA-1:0] exp);
	assert (got === exp)
	else
	begin
		$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
		stop_on_failure();
	end
endtask

// **************************************************
// APB master
// **************************************************
task automatic apb_transfer(input logic wr, input logic [BW_ADDR-1:0] addr,
	input logic [BW_DATA-1:0] wdata, output logic [BW_DATA-1:0] rdata,
	output logic slverr, output int waits);
	int cycles;
	logic done;

	waits = 0;
	done = 1'b0;
	rdata = '0;
	slverr = 1'b0;
	@(posedge clk);
	i_psel <= 1'b1;
	i_penable <= 1'b0;
	i_paddr <= addr;
	i_pwrite <= wr;
	i_pwdata <= wdata;
	// No response while in setup
	@(negedge clk);
	expect_equal("o_pready", 32'(o_pready), 32'h0);
	@(posedge clk);
	i_penable <= 1'b1;
	for (cycles = 0; cycles < READY_TIMEOUT && !done; cycles++)
	begin
		@(negedge clk);
		if (o_pready)
		begin
			rdata = o_prdata;
			slverr = o_pslverr;
			done = 1'b1;
		end
		else
			waits++;
		@(posedge clk);
	end
	i_psel <= 1'b0;
	i_penable <= 1'b0;
	if (!done)
		report_failure("APB transfer timed out waiting for pready");
endtask

task automatic apb_read(input logic [BW_ADDR-1:0] addr, output logic [BW_DATA-1:0] rdata,
	output logic slverr, output int waits);
	apb_transfer(1'b0, addr, $urandom, rdata, slverr, waits);
endtask

task automatic apb_write(input logic [BW_ADDR-1:0] addr, input logic [BW_DATA-1:0] wdata,
	output logic slverr, output int waits);
	logic [BW_DATA-1:0] rdata;

	apb_transfer(1'b1, addr, wdata, rdata, slverr, waits);
endtask

task automatic read_expect(input logic [BW_ADDR-1:0] addr, input logic [BW_DATA-1:0] exp,
	input int exp_waits);
	logic [BW_DATA-1:0] rdata;
	logic slverr;
	int waits;

	apb_read(addr, rdata, slverr, waits);
	expect_equal("o_prdata", rdata, exp);
	expect_equal("o_pslverr", 32'(slverr), 32'h0);
	expect_equal("o_pready wait cycles", 32'(waits), 32'(exp_waits));
endtask

task automatic write_expect(input logic [BW_ADDR-1:0] addr, input logic [BW_DATA-1:0] wdata,
	input logic exp_slverr, input int exp_waits);
	logic slverr;
	int waits;

	apb_write(addr, wdata, slverr, waits);
	expect_equal("o_pslverr", 32'(slverr), 32'(exp_slverr));
	expect_equal("o_pready wait cycles", 32'(waits), 32'(exp_waits));
endtask

`endif

/* test/tb_pctrl.sv */
module tb_pctrl
	import pctrl_pkg::*;
();

	localparam int READY_TIMEOUT = 16;
	// Edges watched after a reset run a little past the last automatic release
	localparam int SEQ_CHECK_LEN = GLOBAL_HOLD + NUM_AUTO_RESET * SEQ_STEP + 2;
	localparam int EXT_TRANSFERS = 12;

	logic clk;
	logic i_rst_n;
	logic i_psel;
	logic i_penable;
	logic [BW_ADDR-1:0] i_paddr;
	logic i_pwrite;
	logic [BW_DATA-1:0] i_pwdata;
	logic [BW_DATA-1:0] o_prdata;
	logic o_pready;
	logic o_pslverr;
	logic [BW_BOOT_MODE-1:0] i_boot_mode;
	logic i_jtag_select;
	logic [BW_INITIALIZED-1:0] i_initialized;
	logic [NUM_CORE*BW_ADDR-1:0] i_pc_list;
	logic [NUM_CORE*BW_DATA-1:0] i_inst_list;
	logic o_global_rst_n;
	logic [NUM_RESET-1:0] o_rst_n_seq;
	logic o_app_finished;
	logic o_ext_psel;
	logic o_ext_penable;
	logic [BW_ADDR-1:0] o_ext_paddr;
	logic o_ext_pwrite;
	logic [BW_DATA-1:0] o_ext_pwdata;
	logic [BW_DATA-1:0] i_ext_prdata;
	logic i_ext_pready;
	logic i_ext_pslverr;

	// Debug network model state
	int ext_delay;
	logic [BW_DATA-1:0] ext_rdata;
	logic ext_slverr;
	logic [BW_ADDR-1:0] ext_addr;
	logic ext_write;
	logic [BW_DATA-1:0] ext_wdata;

	int error_count = 0;

	`include "tb_pctrl_tasks.svh"

	pctrl_top i_dut
	(
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_psel(i_psel),
		.i_penable(i_penable),
		.i_paddr(i_paddr),
		.i_pwrite(i_pwrite),
		.i_pwdata(i_pwdata),
		.o_prdata(o_prdata),
		.o_pready(o_pready),
		.o_pslverr(o_pslverr),
		.i_boot_mode(i_boot_mode),
		.i_jtag_select(i_jtag_select),
		.i_initialized(i_initialized),
		.i_pc_list(i_pc_list),
		.i_inst_list(i_inst_list),
		.o_global_rst_n(o_global_rst_n),
		.o_rst_n_seq(o_rst_n_seq),
		.o_app_finished(o_app_finished),
		.o_ext_psel(o_ext_psel),
		.o_ext_penable(o_ext_penable),
		.o_ext_paddr(o_ext_paddr),
		.o_ext_pwrite(o_ext_pwrite),
		.o_ext_pwdata(o_ext_pwdata),
		.i_ext_prdata(i_ext_prdata),
		.i_ext_pready(i_ext_pready),
		.i_ext_pslverr(i_ext_pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// **************************************************
	// Reference model of the reset sequence
	// **************************************************
	function automatic logic [NUM_RESET-1:0] expected_seq(input int n,
		input logic [NUM_RESET-1:0] rel_bits);
		logic [NUM_RESET-1:0] seq;
		int k;

		seq = '0;
		for (k = 0; k < NUM_AUTO_RESET; k++)
			seq[k] = (n >= GLOBAL_HOLD + (k + 1) * SEQ_STEP);
		// Manual stages need both the release bit and the end of the global reset
		for (k = NUM_AUTO_RESET; k < NUM_RESET; k++)
			seq[k] = rel_bits[k] && (n >= GLOBAL_HOLD);
		return seq;
	endfunction

	// Edge n counts from the last edge that held the sequence in reset
	task automatic check_sequence();
		int n;

		for (n = 0; n <= SEQ_CHECK_LEN; n++)
		begin
			if (n > 0)
				@(posedge clk);
			@(negedge clk);
			expect_equal("o_global_rst_n", 32'(o_global_rst_n), 32'(n >= GLOBAL_HOLD));
			expect_equal("o_rst_n_seq", 32'(o_rst_n_seq), 32'(expected_seq(n, '0)));
		end
	endtask

	// Random upper address bits must not matter
	function automatic logic [BW_ADDR-1:0] make_addr(input int sel,
		input logic [BW_OFFSET-1:0] ofs);
		pctrl_addr_t a;

		a.raw = $urandom;
		a.field.sel = BW_SEL'(sel);
		a.field.offset = ofs;
		return a.raw;
	endfunction

	// **************************************************
	// External debug target
	// **************************************************
	initial
	begin : ext_model
		int d;

		i_ext_pready = 1'b0;
		i_ext_prdata = '0;
		i_ext_pslverr = 1'b0;
		forever
		begin
			@(negedge clk);
			if (o_ext_psel && !o_ext_penable)
			begin
				ext_addr = o_ext_paddr;
				ext_write = o_ext_pwrite;
				ext_wdata = o_ext_pwdata;
				@(posedge clk);
				for (d = 0; d < ext_delay; d++)
				begin
					i_ext_prdata <= ~ext_rdata;
					@(posedge clk);
				end
				i_ext_prdata <= ext_rdata;
				i_ext_pslverr <= ext_slverr;
				i_ext_pready <= 1'b1;
				@(posedge clk);
				i_ext_pready <= 1'b0;
				i_ext_pslverr <= 1'b0;
				i_ext_prdata <= ~ext_rdata;
			end
		end
	end

	// Debug window strobes follow the system bus only for target 3
	initial
	begin : ext_monitor
		pctrl_addr_t a;

		forever
		begin
			@(negedge clk);
			a.raw = i_paddr;
			expect_equal("o_ext_psel", 32'(o_ext_psel),
				32'(i_psel && (a.field.sel == BW_SEL'(SUB_EXTERNAL))));
			expect_equal("o_ext_penable", 32'(o_ext_penable), 32'(i_penable));
		end
	end

	initial
	begin : stimulus
		logic [BW_DATA-1:0] rdata;
		logic slverr;
		int waits;
		int i;
		int k;
		logic [NUM_RESET-1:0] rel;
		logic [BW_ADDR-1:0] addr;
		logic [BW_DATA-1:0] wdata;
		logic wr;
		logic [BW_BOOT_MODE-1:0] boot;
		logic jtag;
		logic [BW_INITIALIZED-1:0] init;
		logic [NUM_CORE*BW_ADDR-1:0] pc_list;
		logic [NUM_CORE*BW_DATA-1:0] inst_list;
		logic [BW_OFFSET-1:0] info_ofs [5];
		logic [BW_DATA-1:0] info_val [5];

		void'($urandom(3));
		i_rst_n = 1'b0;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_paddr = '0;
		i_pwrite = 1'b0;
		i_pwdata = '0;
		i_boot_mode = '0;
		i_jtag_select = 1'b0;
		i_initialized = '0;
		i_pc_list = '0;
		i_inst_list = '0;
		ext_delay = 0;
		ext_rdata = '0;
		ext_slverr = 1'b0;

		// Power-on reset and the full release sequence
		repeat (3) @(posedge clk);
		@(negedge clk);
		expect_equal("o_pready", 32'(o_pready), 32'h0);
		expect_equal("o_app_finished", 32'(o_app_finished), 32'h0);
		expect_equal("o_global_rst_n", 32'(o_global_rst_n), 32'h0);
		expect_equal("o_rst_n_seq", 32'(o_rst_n_seq), 32'h0);
		@(posedge clk);
		i_rst_n <= 1'b1;
		check_sequence();

		// **************************************************
		// Software release and soft reset
		// **************************************************
		for (i = 1; i < 4; i++)
		begin
			rel = NUM_RESET'(i << NUM_AUTO_RESET);
			wdata = $urandom;
			wdata[NUM_RESET-1:NUM_AUTO_RESET] = rel[NUM_RESET-1:NUM_AUTO_RESET];
			write_expect(make_addr(SUB_RESET, OFS_RELEASE), wdata, 1'b0, 0);
			@(negedge clk);
			expect_equal("o_rst_n_seq", 32'(o_rst_n_seq),
				32'(expected_seq(SEQ_CHECK_LEN, rel)));
			read_expect(make_addr(SUB_RESET, OFS_RELEASE),
				32'(expected_seq(SEQ_CHECK_LEN, rel)), 0);
		end

		write_expect(make_addr(SUB_RESET, OFS_SOFT_RESET), RESET_KEY ^ 32'h1, 1'b0, 0);
		for (k = 0; k < 4; k++)
		begin
			@(negedge clk);
			expect_equal("o_global_rst_n", 32'(o_global_rst_n), 32'h1);
			expect_equal("o_rst_n_seq", 32'(o_rst_n_seq),
				32'(expected_seq(SEQ_CHECK_LEN, rel)));
		end
		write_expect(make_addr(SUB_RESET, OFS_SOFT_RESET), RESET_KEY, 1'b0, 0);
		check_sequence();

		// **************************************************
		// Platform registers
		// **************************************************
		for (i = 0; i < 3; i++)
		begin
			boot = BW_BOOT_MODE'($urandom);
			jtag = 1'($urandom);
			init = BW_INITIALIZED'($urandom);
			for (k = 0; k < NUM_CORE; k++)
			begin
				pc_list[k*BW_ADDR +: BW_ADDR] = $urandom;
				inst_list[k*BW_DATA +: BW_DATA] = $urandom;
			end
			@(posedge clk);
			i_boot_mode <= boot;
			i_jtag_select <= jtag;
			i_initialized <= init;
			i_pc_list <= pc_list;
			i_inst_list <= inst_list;
			read_expect(make_addr(SUB_PLATFORM, OFS_BOOT_MODE), 32'(boot), 0);
			read_expect(make_addr(SUB_PLATFORM, OFS_JTAG_SELECT), 32'(jtag), 0);
			read_expect(make_addr(SUB_PLATFORM, OFS_INITIALIZED), 32'(init), 0);
			for (k = 0; k < NUM_CORE; k++)
			begin
				read_expect(make_addr(SUB_PLATFORM, BW_OFFSET'(OFS_CORE_BASE + 8 * k)),
					pc_list[k*BW_ADDR +: BW_ADDR], 0);
				read_expect(make_addr(SUB_PLATFORM, BW_OFFSET'(OFS_CORE_BASE + 8 * k + 4)),
					inst_list[k*BW_DATA +: BW_DATA], 0);
			end
		end

		write_expect(make_addr(SUB_PLATFORM, OFS_APP_FINISHED), 32'h1, 1'b0, 0);
		@(negedge clk);
		expect_equal("o_app_finished", 32'(o_app_finished), 32'h1);
		read_expect(make_addr(SUB_PLATFORM, OFS_APP_FINISHED), 32'h1, 0);
		write_expect(make_addr(SUB_PLATFORM, OFS_APP_FINISHED), 32'h0, 1'b0, 0);
		@(negedge clk);
		expect_equal("o_app_finished", 32'(o_app_finished), 32'h0);
		write_expect(make_addr(SUB_PLATFORM, OFS_JTAG_SELECT), 32'h1, 1'b1, 0);
		@(negedge clk);
		expect_equal("o_app_finished", 32'(o_app_finished), 32'h0);

		// **************************************************
		// Design info with one wait state on every access
		// **************************************************
		info_ofs = '{OFS_DESIGN_ID, OFS_VERSION, OFS_NUM_CORE, OFS_NUM_RESET, 10'h010};
		info_val = '{DESIGN_ID, VERSION, 32'(NUM_CORE), 32'(NUM_RESET), 32'h0};
		for (i = 0; i < 5; i++)
			read_expect(make_addr(SUB_DESIGN_INFO, info_ofs[i]), info_val[i], 1);
		write_expect(make_addr(SUB_DESIGN_INFO, OFS_DESIGN_ID), $urandom, 1'b1, 1);

		// **************************************************
		// External debug window
		// **************************************************
		for (i = 0; i < EXT_TRANSFERS; i++)
		begin
			addr = make_addr(SUB_EXTERNAL, BW_OFFSET'($urandom));
			wr = 1'($urandom);
			wdata = $urandom;
			ext_delay = int'($urandom_range(3, 0));
			ext_rdata = $urandom;
			ext_slverr = 1'($urandom);
			apb_transfer(wr, addr, wdata, rdata, slverr, waits);
			expect_equal("o_ext_paddr", ext_addr, addr);
			expect_equal("o_ext_pwrite", 32'(ext_write), 32'(wr));
			expect_equal("o_ext_pwdata", ext_wdata, wdata);
			expect_equal("o_prdata", rdata, ext_rdata);
			expect_equal("o_pslverr", 32'(slverr), 32'(ext_slverr));
			expect_equal("o_pready wait cycles", 32'(waits), 32'(ext_delay));
		end

		@(posedge clk);
		if (error_count == 0)
		begin
			$display("*** PASSED ***");
			$finish;
		end
		else
			stop_on_failure();
	end

endmodule

/* source/pctrl_top.sv */
module pctrl_top
	import pctrl_pkg::*;
(
	input  logic                         clk,
	input  logic                         i_rst_n,

	// APB slave from the system bus
	input  logic                         i_psel,
	input  logic                         i_penable,
	input  logic [BW_ADDR-1:0]           i_paddr,
	input  logic                         i_pwrite,
	input  logic [BW_DATA-1:0]           i_pwdata,
	output logic [BW_DATA-1:0]           o_prdata,
	output logic                         o_pready,
	output logic                         o_pslverr,

	input  logic [BW_BOOT_MODE-1:0]      i_boot_mode,
	input  logic                         i_jtag_select,
	input  logic [BW_INITIALIZED-1:0]    i_initialized,
	input  logic [NUM_CORE*BW_ADDR-1:0]  i_pc_list,
	input  logic [NUM_CORE*BW_DATA-1:0]  i_inst_list,

	output logic                         o_global_rst_n,
	output logic [NUM_RESET-1:0]         o_rst_n_seq,
	output logic                         o_app_finished,

	// APB master toward the debug network
	output logic                         o_ext_psel,
	output logic                         o_ext_penable,
	output logic [BW_ADDR-1:0]           o_ext_paddr,
	output logic                         o_ext_pwrite,
	output logic [BW_DATA-1:0]           o_ext_pwdata,
	input  logic [BW_DATA-1:0]           i_ext_prdata,
	input  logic                         i_ext_pready,
	input  logic                         i_ext_pslverr
);

	logic [NUM_SUBMODULE-1:0] sub_psel;
	logic penable;
	logic [BW_ADDR-1:0] paddr;
	logic pwrite;
	logic [BW_DATA-1:0] pwdata;
	logic [NUM_SUBMODULE*BW_DATA-1:0] sub_prdata;
	logic [NUM_SUBMODULE-1:0] sub_pready;
	logic [NUM_SUBMODULE-1:0] sub_pslverr;

	// **************************************************
	// Address decoder
	// **************************************************
	pctrl_apb_bus i_apb_bus
	(
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_psel(i_psel),
		.i_penable(i_penable),
		.i_paddr(i_paddr),
		.i_pwrite(i_pwrite),
		.i_pwdata(i_pwdata),
		.o_prdata(o_prdata),
		.o_pready(o_pready),
		.o_pslverr(o_pslverr),
		.o_sub_psel(sub_psel),
		.o_penable(penable),
		.o_paddr(paddr),
		.o_pwrite(pwrite),
		.o_pwdata(pwdata),
		.i_sub_prdata(sub_prdata),
		.i_sub_pready(sub_pready),
		.i_sub_pslverr(sub_pslverr)
	);

	// **************************************************
	// Local register blocks
	// **************************************************
	pctrl_reset_seq i_reset_seq
	(
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_psel(sub_psel[SUB_RESET]),
		.i_penable(penable),
		.i_paddr(paddr),
		.i_pwrite(pwrite),
		.i_pwdata(pwdata),
		.o_prdata(sub_prdata[SUB_RESET*BW_DATA +: BW_DATA]),
		.o_pready(sub_pready[SUB_RESET]),
		.o_pslverr(sub_pslverr[SUB_RESET]),
		.o_global_rst_n(o_global_rst_n),
		.o_rst_n_seq(o_rst_n_seq)
	);

	pctrl_platform_regs i_platform_regs
	(
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_psel(sub_psel[SUB_PLATFORM]),
		.i_penable(penable),
		.i_paddr(paddr),
		.i_pwrite(pwrite),
		.i_pwdata(pwdata),
		.o_prdata(sub_prdata[SUB_PLATFORM*BW_DATA +: BW_DATA]),
		.o_pready(sub_pready[SUB_PLATFORM]),
		.o_pslverr(sub_pslverr[SUB_PLATFORM]),
		.i_boot_mode(i_boot_mode),
		.i_jtag_select(i_jtag_select),
		.i_initialized(i_initialized),
		.i_pc_list(i_pc_list),
		.i_inst_list(i_inst_list),
		.o_app_finished(o_app_finished)
	);

	pctrl_design_info i_design_info
	(
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_psel(sub_psel[SUB_DESIGN_INFO]),
		.i_penable(penable),
		.i_paddr(paddr),
		.i_pwrite(pwrite),
		.i_pwdata(pwdata),
		.o_prdata(sub_prdata[SUB_DESIGN_INFO*BW_DATA +: BW_DATA]),
		.o_pready(sub_pready[SUB_DESIGN_INFO]),
		.o_pslverr(sub_pslverr[SUB_DESIGN_INFO])
	);

	// **************************************************
	// External debug window
	// **************************************************
	assign o_ext_psel = sub_psel[SUB_EXTERNAL];
	assign o_ext_penable = penable;
	assign o_ext_paddr = paddr;
	assign o_ext_pwrite = pwrite;
	assign o_ext_pwdata = pwdata;
	assign sub_prdata[SUB_EXTERNAL*BW_DATA +: BW_DATA] = i_ext_prdata;
	assign sub_pready[SUB_EXTERNAL] = i_ext_pready;
	assign sub_pslverr[SUB_EXTERNAL] = i_ext_pslverr;

endmodule

/* source/pctrl_design_info.sv */
module pctrl_design_info
	import pctrl_pkg::*;
(
	input  logic               clk,
	input  logic               i_rst_n,

	input  logic               i_psel,
	input  logic               i_penable,
	input  logic [BW_ADDR-1:0] i_paddr,
	input  logic               i_pwrite,
	input  logic [BW_DATA-1:0] i_pwdata,
	output logic [BW_DATA-1:0] o_prdata,
	output logic               o_pready,
	output logic               o_pslverr
);

	pctrl_addr_t addr;
	logic access;
	logic wait_q;
	logic [BW_DATA-1:0] rom_word;
	logic [BW_DATA-1:0] rdata_q;

	assign addr.raw = i_paddr;
	assign access = i_psel & i_penable;

	// First access cycle loads the word and the second one completes
	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
			wait_q <= 1'b0;
		else
			wait_q <= access & ~wait_q;
	end

	always_comb
	begin
		case (addr.field.offset)
			OFS_DESIGN_ID: rom_word = DESIGN_ID;
			OFS_VERSION:   rom_word = VERSION;
			OFS_NUM_CORE:  rom_word = BW_DATA'(NUM_CORE);
			OFS_NUM_RESET: rom_word = BW_DATA'(NUM_RESET);
			default:       rom_word = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
			rdata_q <= '0;
		else if (access && !wait_q)
			rdata_q <= rom_word;
	end

	assign o_prdata = rdata_q;
	assign o_pready = access & wait_q;
	// The ROM drops write data and only flags the attempt
	assign o_pslverr = o_pready & i_pwrite;

endmodule

/* source/pctrl_platform_regs.sv */
module pctrl_platform_regs
	import pctrl_pkg::*;
(
	input  logic                         clk,
	input  logic                         i_rst_n,

	input  logic                         i_psel,
	input  logic                         i_penable,
	input  logic [BW_ADDR-1:0]           i_paddr,
	input  logic                         i_pwrite,
	input  logic [BW_DATA-1:0]           i_pwdata,
	output logic [BW_DATA-1:0]           o_prdata,
	output logic                         o_pready,
	output logic                         o_pslverr,

	input  logic [BW_BOOT_MODE-1:0]      i_boot_mode,
	input  logic                         i_jtag_select,
	input  logic [BW_INITIALIZED-1:0]    i_initialized,
	input  logic [NUM_CORE*BW_ADDR-1:0]  i_pc_list,
	input  logic [NUM_CORE*BW_DATA-1:0]  i_inst_list,
	output logic                         o_app_finished
);

	pctrl_addr_t addr;
	logic [BW_OFFSET-1:0] ofs;
	logic access;
	logic finished_q;

	assign addr.raw = i_paddr;
	assign ofs = addr.field.offset;
	assign access = i_psel & i_penable;

	assign o_pready = access;
	// Everything except the finish flag is read-only
	assign o_pslverr = access & i_pwrite & (ofs != OFS_APP_FINISHED);

	// **************************************************
	// Finish flag
	// **************************************************
	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
			finished_q <= 1'b0;
		else if (access && i_pwrite && (ofs == OFS_APP_FINISHED))
			finished_q <= i_pwdata[0];
	end

	assign o_app_finished = finished_q;

	// **************************************************
	// Read mux
	// **************************************************
	always_comb
	begin
		o_prdata = '0;
		case (ofs)
			OFS_BOOT_MODE:
				o_prdata[BW_BOOT_MODE-1:0] = i_boot_mode;
			OFS_JTAG_SELECT:
				o_prdata[0] = i_jtag_select;
			OFS_INITIALIZED:
				o_prdata[BW_INITIALIZED-1:0] = i_initialized;
			OFS_APP_FINISHED:
				o_prdata[0] = finished_q;
			default:
			begin
				// Per-core pairs: PC, then instruction 4 bytes above
				for (int k = 0; k < NUM_CORE; k++)
				begin
					if (ofs == BW_OFFSET'(OFS_CORE_BASE + 8 * k))
						o_prdata = i_pc_list[k*BW_ADDR +: BW_ADDR];
					if (ofs == BW_OFFSET'(OFS_CORE_BASE + 8 * k + 4))
						o_prdata = i_inst_list[k*BW_DATA +: BW_DATA];
				end
			end
		endcase
	end

endmodule

/* source/pctrl_reset_seq.sv */
module pctrl_reset_seq
	import pctrl_pkg::*;
(
	input  logic                 clk,
	input  logic                 i_rst_n,

	input  logic                 i_psel,
	input  logic                 i_penable,
	input  logic [BW_ADDR-1:0]   i_paddr,
	input  logic                 i_pwrite,
	input  logic [BW_DATA-1:0]   i_pwdata,
	output logic [BW_DATA-1:0]   o_prdata,
	output logic                 o_pready,
	output logic                 o_pslverr,

	output logic                 o_global_rst_n,
	output logic [NUM_RESET-1:0] o_rst_n_seq
);

	pctrl_addr_t addr;
	logic wr_access;
	logic soft_reset;
	logic [BW_SEQ_CNT-1:0] seq_cnt;
	logic global_rst_n_q;
	logic [NUM_AUTO_RESET-1:0] auto_rst_n_q;
	logic [NUM_MANUAL_RESET-1:0] release_q;

	assign addr.raw = i_paddr;

	// Zero wait states, never an error
	assign o_pready = i_psel & i_penable;
	assign o_pslverr = 1'b0;
	assign wr_access = o_pready & i_pwrite;

	// Only the key restarts the sequence
	assign soft_reset = wr_access && (addr.field.offset == OFS_SOFT_RESET)
		&& (i_pwdata == RESET_KEY);

	// **************************************************
	// Sequence counter and automatic releases
	// **************************************************
	always_ff @(posedge clk)
	begin
		if (!i_rst_n || soft_reset)
		begin
			seq_cnt <= '0;
			global_rst_n_q <= 1'b0;
			auto_rst_n_q <= '0;
		end
		else
		begin
			if (seq_cnt != BW_SEQ_CNT'(SEQ_END))
				seq_cnt <= seq_cnt + 1'b1;
			if (seq_cnt == BW_SEQ_CNT'(GLOBAL_HOLD - 1))
				global_rst_n_q <= 1'b1;
			// Stage k follows the global release by (k+1) steps
			for (int k = 0; k < NUM_AUTO_RESET; k++)
				if (seq_cnt == BW_SEQ_CNT'(GLOBAL_HOLD + (k + 1) * SEQ_STEP - 1))
					auto_rst_n_q[k] <= 1'b1;
		end
	end

	// **************************************************
	// Software release of the manual stages
	// **************************************************
	always_ff @(posedge clk)
	begin
		if (!i_rst_n || soft_reset)
			release_q <= '0;
		else if (wr_access && (addr.field.offset == OFS_RELEASE))
			release_q <= i_pwdata[NUM_RESET-1:NUM_AUTO_RESET];
	end

	assign o_global_rst_n = global_rst_n_q;

	// Manual stages held while the global reset is still active
	assign o_rst_n_seq = {release_q & {NUM_MANUAL_RESET{global_rst_n_q}}, auto_rst_n_q};

	always_comb
	begin
		o_prdata = '0;
		if (addr.field.offset == OFS_RELEASE)
			o_prdata[NUM_RESET-1:0] = o_rst_n_seq;
	end

endmodule

/* source/pctrl_apb_bus.sv */
module pctrl_apb_bus
	import pctrl_pkg::*;
(
	input  logic                             clk,
	input  logic                             i_rst_n,

	input  logic                             i_psel,
	input  logic                             i_penable,
	input  logic [BW_ADDR-1:0]               i_paddr,
	input  logic                             i_pwrite,
	input  logic [BW_DATA-1:0]               i_pwdata,
	output logic [BW_DATA-1:0]               o_prdata,
	output logic                             o_pready,
	output logic                             o_pslverr,

	output logic [NUM_SUBMODULE-1:0]         o_sub_psel,
	output logic                             o_penable,
	output logic [BW_ADDR-1:0]               o_paddr,
	output logic                             o_pwrite,
	output logic [BW_DATA-1:0]               o_pwdata,
	input  logic [NUM_SUBMODULE*BW_DATA-1:0] i_sub_prdata,
	input  logic [NUM_SUBMODULE-1:0]         i_sub_pready,
	input  logic [NUM_SUBMODULE-1:0]         i_sub_pslverr
);

	pctrl_addr_t addr;
	logic [BW_SEL-1:0] sel_q;
	logic [BW_SEL-1:0] cur_sel;
	logic access;

	assign addr.raw = i_paddr;
	assign access = i_psel & i_penable;

	// **************************************************
	// Target select
	// **************************************************

	// Index latched in setup, held through the access phase
	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
			sel_q <= '0;
		else if (i_psel && !i_penable)
			sel_q <= addr.field.sel;
	end

	assign cur_sel = i_penable ? sel_q : addr.field.sel;

	always_comb
	begin
		o_sub_psel = '0;
		o_sub_psel[cur_sel] = i_psel;
	end

	// Shared request lines
	assign o_penable = i_penable;
	assign o_paddr = addr.raw;
	assign o_pwrite = i_pwrite;
	assign o_pwdata = i_pwdata;

	// **************************************************
	// Response mux
	// **************************************************
	assign o_prdata = i_sub_prdata[cur_sel*BW_DATA +: BW_DATA];
	assign o_pready = access & i_sub_pready[cur_sel];
	assign o_pslverr = o_pready & i_sub_pslverr[cur_sel];

endmodule

/* source/pctrl_pkg.sv */
package pctrl_pkg;

	// **************************************************
	// APB widths and address decode
	// **************************************************
	localparam int BW_ADDR = 32;
	localparam int BW_DATA = 32;

	localparam int NUM_SUBMODULE = 4;
	localparam int BW_SEL = 2;
	localparam int BW_OFFSET = 10;

	localparam int SUB_RESET = 0;
	localparam int SUB_PLATFORM = 1;
	localparam int SUB_DESIGN_INFO = 2;
	localparam int SUB_EXTERNAL = 3;

	// **************************************************
	// Platform sizes and reset sequencing
	// **************************************************
	localparam int NUM_CORE = 2;
	localparam int NUM_RESET = 4;
	localparam int NUM_AUTO_RESET = 2;
	localparam int NUM_MANUAL_RESET = NUM_RESET - NUM_AUTO_RESET;
	localparam int BW_BOOT_MODE = 2;
	localparam int BW_INITIALIZED = 2;

	localparam int GLOBAL_HOLD = 8;
	localparam int SEQ_STEP = 4;
	// Counter saturates once the last automatic stage is out
	localparam int SEQ_END = GLOBAL_HOLD + NUM_AUTO_RESET * SEQ_STEP;
	localparam int BW_SEQ_CNT = $clog2(SEQ_END + 1);
	localparam logic [BW_DATA-1:0] RESET_KEY = 32'hA5C3_0F1E;

	// **************************************************
	// Register offsets and ROM contents
	// **************************************************
	localparam logic [BW_OFFSET-1:0] OFS_SOFT_RESET = 10'h000;
	localparam logic [BW_OFFSET-1:0] OFS_RELEASE = 10'h004;

	localparam logic [BW_OFFSET-1:0] OFS_BOOT_MODE = 10'h000;
	localparam logic [BW_OFFSET-1:0] OFS_JTAG_SELECT = 10'h004;
	localparam logic [BW_OFFSET-1:0] OFS_INITIALIZED = 10'h008;
	localparam logic [BW_OFFSET-1:0] OFS_APP_FINISHED = 10'h00C;
	localparam logic [BW_OFFSET-1:0] OFS_CORE_BASE = 10'h010;

	localparam logic [BW_OFFSET-1:0] OFS_DESIGN_ID = 10'h000;
	localparam logic [BW_OFFSET-1:0] OFS_VERSION = 10'h004;
	localparam logic [BW_OFFSET-1:0] OFS_NUM_CORE = 10'h008;
	localparam logic [BW_OFFSET-1:0] OFS_NUM_RESET = 10'h00C;

	localparam logic [BW_DATA-1:0] DESIGN_ID = 32'h5043_5452;
	localparam logic [BW_DATA-1:0] VERSION = 32'h0001_0200;

	// Raw bus address, or split into target select and register offset
	typedef union packed {
		logic [BW_ADDR-1:0] raw;
		struct packed {
			logic [BW_ADDR-BW_SEL-BW_OFFSET-1:0] upper;
			logic [BW_SEL-1:0] sel;
			logic [BW_OFFSET-1:0] offset;
		} field;
	} pctrl_addr_t;

endpackage
